//--- include/phy_mem_defines.svh
`ifndef PHY_MEM_DEFINES_SVH
`define PHY_MEM_DEFINES_SVH

// device address map
`define COM_DATA_ADDR   32'h1FD0_03F8  // low byte only
`define COM_STAT_ADDR   32'h1FD0_03FC  // {30'b0, read_ready, write_ready}
`define SEGDISP_ADDR    32'h1FD0_0400
`define VGA_ADDR_START  32'h1A00_0000
`define VGA_ADDR_END    32'h1A09_6000  // exclusive
`define KEYBOARD_ADDR   32'h0F00_0000

// region prefixes
`define ROM_BASE        20'h10000      // addr[31:12]
`define FLASH_PREFIX    8'h1E          // addr[31:24]
`define RAM_ADDR_MASK   32'h007F_FFFF  // ram fits in 23 bits

// rom geometry
`define ROM_ADDR_WIDTH  12
`define ROM_DEPTH       16

// vga frame buffer write port
`define VGA_ADDR_WIDTH  18
`define VGA_DATA_WIDTH  8

// write timing in clk50M cycles
`define RAM_WRITE_WIDTH            1
`define RAM_WRITE_READ_RECOVERY    1
`define FLASH_WRITE_WIDTH          4
`define FLASH_WRITE_READ_RECOVERY  2

`endif

//--- verilog/phy_mem_pkg.sv
`default_nettype none

`include "phy_mem_defines.svh"

package phy_mem_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [19:0] sram_addr_t;
	typedef logic [22:0] flash_addr_t;
	typedef logic [15:0] half_t;
	typedef logic [7:0]  byte_t;
	typedef logic [`VGA_ADDR_WIDTH-1:0] vga_addr_t;
	typedef logic [`VGA_DATA_WIDTH-1:0] vga_data_t;

	// one-hot address decode
	typedef struct packed {
		logic ram;
		logic com_data;
		logic com_stat;
		logic flash;
		logic segdisp;
		logic rom;
		logic vga;
		logic keyboard;
	} region_t;

	typedef struct packed {
		addr_t addr;
		word_t data;
	} write_latch_t;

	// ce, oe and we are active low
	typedef struct packed {
		sram_addr_t addr;
		logic       ce;
		logic       oe;
		logic       we;
		word_t      data;
	} sram_bus_t;

	// pin order of the flash control byte
	typedef struct packed {
		logic byte_mode;
		logic ce;
		logic ce1;
		logic ce2;
		logic oe;
		logic rp;
		logic vpen;
		logic we;
	} flash_ctl_t;

	typedef enum logic [1:0] {
		ST_READ,
		ST_WRITE_RAM,
		ST_WRITE_FLASH,
		ST_RECOVERY
	} mem_state_t;

	// image 0 memory transfer, image 1 bootloader
	localparam word_t rom_image [0:1][0:`ROM_DEPTH-1] = '{
		'{32'h3c08_1e00, 32'h3c09_0000, 32'h240a_0100, 32'h8d0b_0000,
		  32'had2b_0000, 32'h2508_0004, 32'h2529_0004, 32'h254a_ffff,
		  32'h1540_fffa, 32'h0000_0000, 32'h3c1f_0000, 32'h03e0_0008,
		  32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
		'{32'h3c1d_007f, 32'h37bd_fffc, 32'h3c08_1fd0, 32'h3508_03fc,
		  32'h8d09_0000, 32'h3129_0002, 32'h1120_fffd, 32'h0000_0000,
		  32'h8d0a_fffc, 32'h3c0b_0000, 32'had6a_0000, 32'h0800_0004,
		  32'h0000_0000, 32'h1000_ffff, 32'h0000_0000, 32'hdead_beef}
	};

endpackage

`default_nettype wire

//--- verilog/phy_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "phy_mem_defines.svh"

module phy_addr_decode (
	input  wire phy_mem_pkg::addr_t   addr,
	output phy_mem_pkg::region_t      region,
	output logic [20:0]               ram_word,
	output phy_mem_pkg::vga_addr_t    vga_offset
);

	phy_mem_pkg::addr_t vga_byte_off;  // byte offset into the frame buffer
	logic               in_vga;

	assign in_vga = (addr >= `VGA_ADDR_START) && (addr < `VGA_ADDR_END);
	assign vga_byte_off = addr - `VGA_ADDR_START;

	// regions do not overlap, so at most one bit is set
	assign region = '{
		ram:      ((addr & `RAM_ADDR_MASK) == addr),
		com_data: (addr == `COM_DATA_ADDR),
		com_stat: (addr == `COM_STAT_ADDR),
		flash:    (addr[31:24] == `FLASH_PREFIX),
		segdisp:  (addr == `SEGDISP_ADDR),
		rom:      (addr[31:12] == `ROM_BASE),
		vga:      in_vga,
		keyboard: (addr == `KEYBOARD_ADDR)
	};

	// bit 20 of the word address picks the bank
	assign ram_word = addr[22:2];

	// one pixel per bus word
	assign vga_offset = vga_byte_off[`VGA_ADDR_WIDTH+1:2];

endmodule

`default_nettype wire

//--- verilog/phy_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "phy_mem_defines.svh"

module phy_mem_ctrl (
	input  wire logic                    clk50M,
	input  wire logic                    rst,
	input  wire logic                    is_write,
	input  wire phy_mem_pkg::addr_t      addr,
	input  wire phy_mem_pkg::word_t      data_in,
	input  wire phy_mem_pkg::region_t    region,
	input  wire phy_mem_pkg::vga_addr_t  vga_offset,
	output phy_mem_pkg::mem_state_t      state,
	output phy_mem_pkg::write_latch_t    wlatch,
	output logic                         sram_write,
	output logic                         flash_write,
	output logic                         busy,
	output logic                         enable_com_write,
	output phy_mem_pkg::byte_t           com_data_out,
	output phy_mem_pkg::word_t           segdisp,
	output phy_mem_pkg::vga_addr_t       vga_write_addr,
	output phy_mem_pkg::vga_data_t       vga_write_data,
	output logic                         vga_write_enable,
	output logic                         int_com_ack,
	output logic                         kbd_int_ack
);

	localparam logic [3:0] RAM_PULSE   = 4'(`RAM_WRITE_WIDTH);
	localparam logic [3:0] RAM_DONE    = 4'(`RAM_WRITE_WIDTH + `RAM_WRITE_READ_RECOVERY);
	localparam logic [3:0] FLASH_PULSE = 4'(`FLASH_WRITE_WIDTH);
	localparam logic [3:0] FLASH_DONE  = 4'(`FLASH_WRITE_WIDTH + `FLASH_WRITE_READ_RECOVERY);

	logic       is_write_prev;
	logic       write_start;
	logic [3:0] write_cnt;       // cycles since entering a write state
	logic [3:0] write_cnt_next;

	// only a fresh edge in the read state starts a write
	assign write_start = is_write && !is_write_prev && (state == phy_mem_pkg::ST_READ);
	assign write_cnt_next = write_cnt + 4'd1;

	assign busy = (state != phy_mem_pkg::ST_READ) || is_write;

	assign sram_write = (state == phy_mem_pkg::ST_WRITE_RAM) && (write_cnt < RAM_PULSE);
	assign flash_write = (state == phy_mem_pkg::ST_WRITE_FLASH) && (write_cnt < FLASH_PULSE);

	assign com_data_out = wlatch.data[7:0];

	always_ff @(posedge clk50M) begin
		if (rst) begin
			state            <= phy_mem_pkg::ST_READ;
			is_write_prev    <= 1'b0;
			write_cnt        <= '0;
			enable_com_write <= 1'b0;
			vga_write_enable <= 1'b0;
			segdisp          <= '0;
			int_com_ack      <= 1'b0;
			kbd_int_ack      <= 1'b0;
		end else begin
			is_write_prev    <= is_write;
			enable_com_write <= 1'b0;  // single cycle strobes
			vga_write_enable <= 1'b0;
			int_com_ack      <= region.com_data && !is_write;
			kbd_int_ack      <= region.keyboard && !is_write;

			case (state)
				phy_mem_pkg::ST_READ: begin
					if (write_start) begin
						write_cnt <= '0;
						if (region.ram)
							state <= phy_mem_pkg::ST_WRITE_RAM;
						else if (region.flash)
							state <= phy_mem_pkg::ST_WRITE_FLASH;
						else if (region.com_data)
							enable_com_write <= 1'b1;
						else if (region.segdisp)
							segdisp <= data_in;
						else if (region.vga) begin
							vga_write_enable <= 1'b1;
							state <= phy_mem_pkg::ST_RECOVERY;
						end
					end
				end
				phy_mem_pkg::ST_WRITE_RAM: begin
					write_cnt <= write_cnt_next;
					if (write_cnt_next == RAM_DONE)
						state <= phy_mem_pkg::ST_RECOVERY;
				end
				phy_mem_pkg::ST_WRITE_FLASH: begin
					write_cnt <= write_cnt_next;
					if (write_cnt_next == FLASH_DONE)
						state <= phy_mem_pkg::ST_RECOVERY;
				end
				phy_mem_pkg::ST_RECOVERY:
					state <= phy_mem_pkg::ST_READ;
				default:
					state <= phy_mem_pkg::ST_READ;
			endcase
		end
	end

	// write payload, held until the next accepted write
	always_ff @(posedge clk50M) begin
		if (write_start) begin
			wlatch <= '{addr: addr, data: data_in};
			if (region.vga) begin
				vga_write_addr <= vga_offset;
				vga_write_data <= data_in[7:0];
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/phy_sram_port.sv
`timescale 1ns/1ps
`default_nettype none

module phy_sram_port (
	input  wire phy_mem_pkg::mem_state_t    state,
	input  wire logic                       sram_write,
	input  wire phy_mem_pkg::write_latch_t  wlatch,
	input  wire logic [20:0]                ram_word,
	output phy_mem_pkg::sram_bus_t          baseram,
	output phy_mem_pkg::sram_bus_t          extram,
	output logic                            ram_bank
);

	logic        ram_cycle;   // write in progress, latched address owns the bus
	logic [20:0] word;

	// pins of one bank; an unselected bank stays fully deselected
	function automatic phy_mem_pkg::sram_bus_t bank_bus(
		input logic                sel,
		input logic                wr_cycle,
		input logic                wr_pulse,
		input phy_mem_pkg::sram_addr_t a,
		input phy_mem_pkg::word_t  d
	);
		phy_mem_pkg::sram_bus_t b;
		b.addr = a;
		b.ce   = ~sel;
		b.oe   = ~(sel & ~wr_cycle);  // read enable off for the whole write
		b.we   = ~(sel & wr_pulse);
		b.data = d;
		return b;
	endfunction

	assign ram_cycle = (state == phy_mem_pkg::ST_WRITE_RAM);
	assign word = ram_cycle ? wlatch.addr[22:2] : ram_word;
	assign ram_bank = word[20];  // 1 selects ext

	assign baseram = bank_bus(~ram_bank, ram_cycle, sram_write, word[19:0], wlatch.data);
	assign extram  = bank_bus(ram_bank, ram_cycle, sram_write, word[19:0], wlatch.data);

endmodule

`default_nettype wire

//--- verilog/phy_flash_port.sv
`timescale 1ns/1ps
`default_nettype none

module phy_flash_port (
	input  wire phy_mem_pkg::mem_state_t    state,
	input  wire logic                       flash_write,
	input  wire phy_mem_pkg::write_latch_t  wlatch,
	input  wire phy_mem_pkg::addr_t         addr,
	output phy_mem_pkg::flash_addr_t        flash_addr,
	output phy_mem_pkg::half_t              flash_dout,
	output logic                            flash_drive,
	output phy_mem_pkg::flash_ctl_t         flash_ctl
);

	assign flash_drive = (state == phy_mem_pkg::ST_WRITE_FLASH);

	// halfword addressing, byte bit dropped
	assign flash_addr = flash_drive ? wlatch.addr[23:1] : addr[23:1];
	assign flash_dout = wlatch.data[15:0];

	assign flash_ctl = '{
		byte_mode: 1'b1,   // 16-bit mode
		ce:        1'b0,
		ce1:       1'b0,
		ce2:       1'b0,
		oe:        flash_drive,
		rp:        1'b1,
		vpen:      1'b1,
		we:        ~flash_write
	};

endmodule

`default_nettype wire

//--- verilog/phy_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "phy_mem_defines.svh"

module phy_read_mux (
	input  wire phy_mem_pkg::region_t  region,
	input  wire phy_mem_pkg::addr_t    addr,
	input  wire logic                  ram_bank,
	input  wire phy_mem_pkg::word_t    baseram_din,
	input  wire phy_mem_pkg::word_t    extram_din,
	input  wire phy_mem_pkg::half_t    flash_din,
	input  wire phy_mem_pkg::byte_t    com_data_in,
	input  wire phy_mem_pkg::byte_t    kbd_data,
	input  wire logic                  com_read_ready,
	input  wire logic                  com_write_ready,
	input  wire logic                  rom_selector,
	output phy_mem_pkg::word_t         data_out
);

	localparam int ROM_IDX_W = $clog2(`ROM_DEPTH);

	logic [`ROM_ADDR_WIDTH-1:0] rom_addr;
	logic [ROM_IDX_W-1:0]       rom_idx;
	logic                       rom_in_image;  // rest of the rom page reads zero

	assign rom_addr = addr[`ROM_ADDR_WIDTH-1:0];
	assign rom_idx = rom_addr[ROM_IDX_W+1:2];
	assign rom_in_image = (rom_addr[`ROM_ADDR_WIDTH-1:ROM_IDX_W+2] == '0);

	always_comb begin
		data_out = '0;
		if (region.ram)
			data_out = ram_bank ? extram_din : baseram_din;
		else if (region.com_data)
			data_out = {24'b0, com_data_in};
		else if (region.com_stat)
			data_out = {30'b0, com_read_ready, com_write_ready};
		else if (region.flash)
			data_out = {16'b0, flash_din};
		else if (region.rom && rom_in_image)
			data_out = phy_mem_pkg::rom_image[rom_selector][rom_idx];
		else if (region.keyboard)
			data_out = {24'b0, kbd_data};
	end

endmodule

`default_nettype wire

//--- verilog/phy_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module phy_mem_top (
	input  wire logic                   clk50M,
	input  wire logic                   rst,
	// cpu bus
	input  wire phy_mem_pkg::addr_t     addr,
	input  wire phy_mem_pkg::word_t     data_in,
	input  wire logic                   is_write,
	output phy_mem_pkg::word_t          data_out,
	output logic                        busy,
	output phy_mem_pkg::word_t          segdisp,
	input  wire logic                   rom_selector,
	// sram banks, data bus split from the pads
	output phy_mem_pkg::sram_bus_t      baseram,
	input  wire phy_mem_pkg::word_t     baseram_din,
	output phy_mem_pkg::sram_bus_t      extram,
	input  wire phy_mem_pkg::word_t     extram_din,
	// serial port
	input  wire phy_mem_pkg::byte_t     com_data_in,
	output phy_mem_pkg::byte_t          com_data_out,
	output logic                        enable_com_write,
	input  wire logic                   com_read_ready,
	input  wire logic                   com_write_ready,
	output logic                        int_com_ack,
	// flash
	output phy_mem_pkg::flash_addr_t    flash_addr,
	input  wire phy_mem_pkg::half_t     flash_din,
	output phy_mem_pkg::half_t          flash_dout,
	output logic                        flash_drive,
	output phy_mem_pkg::flash_ctl_t     flash_ctl,
	// vga and keyboard
	output phy_mem_pkg::vga_addr_t      vga_write_addr,
	output phy_mem_pkg::vga_data_t      vga_write_data,
	output logic                        vga_write_enable,
	input  wire phy_mem_pkg::byte_t     kbd_data,
	output logic                        kbd_int_ack
);

	phy_mem_pkg::region_t       region;
	logic [20:0]                ram_word;
	phy_mem_pkg::vga_addr_t     vga_offset;
	phy_mem_pkg::mem_state_t    state;
	phy_mem_pkg::write_latch_t  wlatch;
	logic                       sram_write;
	logic                       flash_write;
	logic                       ram_bank;

	phy_addr_decode decode_i (
		.addr       (addr),
		.region     (region),
		.ram_word   (ram_word),
		.vga_offset (vga_offset)
	);

	phy_mem_ctrl ctrl_i (
		.clk50M           (clk50M),
		.rst              (rst),
		.is_write         (is_write),
		.addr             (addr),
		.data_in          (data_in),
		.region           (region),
		.vga_offset       (vga_offset),
		.state            (state),
		.wlatch           (wlatch),
		.sram_write       (sram_write),
		.flash_write      (flash_write),
		.busy             (busy),
		.enable_com_write (enable_com_write),
		.com_data_out     (com_data_out),
		.segdisp          (segdisp),
		.vga_write_addr   (vga_write_addr),
		.vga_write_data   (vga_write_data),
		.vga_write_enable (vga_write_enable),
		.int_com_ack      (int_com_ack),
		.kbd_int_ack      (kbd_int_ack)
	);

	phy_sram_port sram_i (
		.state      (state),
		.sram_write (sram_write),
		.wlatch     (wlatch),
		.ram_word   (ram_word),
		.baseram    (baseram),
		.extram     (extram),
		.ram_bank   (ram_bank)
	);

	phy_flash_port flash_i (
		.state       (state),
		.flash_write (flash_write),
		.wlatch      (wlatch),
		.addr        (addr),
		.flash_addr  (flash_addr),
		.flash_dout  (flash_dout),
		.flash_drive (flash_drive),
		.flash_ctl   (flash_ctl)
	);

	phy_read_mux rd_mux_i (
		.region          (region),
		.addr            (addr),
		.ram_bank        (ram_bank),
		.baseram_din     (baseram_din),
		.extram_din      (extram_din),
		.flash_din       (flash_din),
		.com_data_in     (com_data_in),
		.kbd_data        (kbd_data),
		.com_read_ready  (com_read_ready),
		.com_write_ready (com_write_ready),
		.rom_selector    (rom_selector),
		.data_out        (data_out)
	);

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD = 2  // ns, 4 ns clock
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

//--- tb/phy_mem_sva.sv
`timescale 1ns/1ps
`default_nettype none

module phy_mem_sva (
	input wire logic                       clk50M,
	input wire logic                       rst,
	input wire logic                       is_write,
	input wire logic                       busy,
	input wire phy_mem_pkg::addr_t         addr,
	input wire phy_mem_pkg::region_t       region,
	input wire phy_mem_pkg::mem_state_t    state,
	input wire phy_mem_pkg::write_latch_t  wlatch,
	input wire phy_mem_pkg::sram_bus_t     baseram,
	input wire phy_mem_pkg::sram_bus_t     extram,
	input wire phy_mem_pkg::flash_ctl_t    flash_ctl,
	input wire logic                       enable_com_write,
	input wire logic                       vga_write_enable,
	input wire logic                       int_com_ack,
	input wire logic                       kbd_int_ack,
	input wire phy_mem_pkg::word_t         segdisp
);

	int unsigned fail_count = 0;  // polled by the testbench top

	// everything idle in the first cycle out of reset
	assert property (@(posedge clk50M) $fell(rst) |->
		state == phy_mem_pkg::ST_READ && baseram.we && extram.we && flash_ctl.we &&
		!enable_com_write && !vga_write_enable && !int_com_ack && !kbd_int_ack &&
		segdisp == '0)
	else begin
		fail_count++;
		$error("outputs not idle after reset");
	end

	// only the bank picked by address bit 22 is written
	assert property (@(posedge clk50M) disable iff (rst)
		(!baseram.we || !extram.we) |-> state == phy_mem_pkg::ST_WRITE_RAM &&
		baseram.we == wlatch.addr[22] && extram.we == !wlatch.addr[22])
	else begin
		fail_count++;
		$error("sram write enable on the wrong bank or outside a ram write");
	end

	assert property (@(posedge clk50M) disable iff (rst)
		($fell(baseram.we) || $fell(extram.we)) |=> baseram.we && extram.we)
	else begin
		fail_count++;
		$error("sram write pulse longer than one cycle");
	end

	// a new write may raise busy again right after it fell
	assert property (@(posedge clk50M) disable iff (rst)
		$rose(state == phy_mem_pkg::ST_WRITE_RAM) |-> busy ##1 busy ##1 busy
		##1 (!busy || $rose(is_write)))
	else begin
		fail_count++;
		$error("busy did not fall 3 cycles after an sram write");
	end

	assert property (@(posedge clk50M) disable iff (rst)
		$fell(flash_ctl.we) |=> !flash_ctl.we ##1 !flash_ctl.we ##1 !flash_ctl.we
		##1 flash_ctl.we)
	else begin
		fail_count++;
		$error("flash write pulse not 4 cycles");
	end

	assert property (@(posedge clk50M) disable iff (rst)
		$rose(state == phy_mem_pkg::ST_WRITE_FLASH) |-> busy ##1 busy ##1 busy ##1 busy
		##1 busy ##1 busy ##1 busy ##1 !busy)
	else begin
		fail_count++;
		$error("busy not held for 7 cycles after a flash write");
	end

	assert property (@(posedge clk50M) disable iff (rst)
		vga_write_enable |-> state == phy_mem_pkg::ST_RECOVERY ##1 !vga_write_enable)
	else begin
		fail_count++;
		$error("vga write strobe not a single cycle before recovery");
	end

	assert property (@(posedge clk50M) disable iff (rst)
		enable_com_write |=> !enable_com_write)
	else begin
		fail_count++;
		$error("serial write strobe longer than one cycle");
	end

	// acks follow the read address by one cycle
	assert property (@(posedge clk50M) disable iff (rst)
		int_com_ack == $past(region.com_data && !is_write) &&
		kbd_int_ack == $past(region.keyboard && !is_write))
	else begin
		fail_count++;
		$error("read acknowledge does not match the previous cycle's read");
	end

	assert property (@(posedge clk50M) disable iff (rst)
		(is_write || state == phy_mem_pkg::ST_READ) |-> addr[1:0] == 2'b00)
	else begin
		fail_count++;
		$error("unaligned bus address");
	end

endmodule

bind phy_mem_top phy_mem_sva sva_i (.*);

`default_nettype wire

//--- tb/phy_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "phy_mem_defines.svh"

module phy_mem_tb;

	localparam int TIMEOUT_CYCLES = 2000;  // tests need about 110 cycles

	logic                       clk50M;
	logic                       rst;
	phy_mem_pkg::addr_t         addr;
	phy_mem_pkg::word_t         data_in;
	logic                       is_write;
	phy_mem_pkg::word_t         data_out;
	logic                       busy;
	phy_mem_pkg::word_t         segdisp;
	logic                       rom_selector;
	phy_mem_pkg::sram_bus_t     baseram;
	phy_mem_pkg::word_t         baseram_din;
	phy_mem_pkg::sram_bus_t     extram;
	phy_mem_pkg::word_t         extram_din;
	phy_mem_pkg::byte_t         com_data_in;
	phy_mem_pkg::byte_t         com_data_out;
	logic                       enable_com_write;
	logic                       com_read_ready;
	logic                       com_write_ready;
	logic                       int_com_ack;
	phy_mem_pkg::flash_addr_t   flash_addr;
	phy_mem_pkg::half_t         flash_din;
	phy_mem_pkg::half_t         flash_dout;
	logic                       flash_drive;
	phy_mem_pkg::flash_ctl_t    flash_ctl;
	phy_mem_pkg::vga_addr_t     vga_write_addr;
	phy_mem_pkg::vga_data_t     vga_write_data;
	logic                       vga_write_enable;
	phy_mem_pkg::byte_t         kbd_data;
	logic                       kbd_int_ack;

	phy_mem_pkg::word_t base_mem [0:63];
	phy_mem_pkg::word_t ext_mem [0:63];
	phy_mem_pkg::half_t flash_mem [0:15];
	int unsigned        cycle_count = 0;

	tb_clock clock_i (.clk(clk50M));

	phy_mem_top dut_i (.*);

	// async sram and flash models, write while we is low
	assign baseram_din = base_mem[baseram.addr[5:0]];
	assign extram_din = ext_mem[extram.addr[5:0]];
	assign flash_din = flash_mem[flash_addr[3:0]];

	always @(posedge clk50M) begin
		if (!baseram.ce && !baseram.we)
			base_mem[baseram.addr[5:0]] <= baseram.data;
		if (!extram.ce && !extram.we)
			ext_mem[extram.addr[5:0]] <= extram.data;
		if (!flash_ctl.ce && !flash_ctl.we && flash_drive)
			flash_mem[flash_addr[3:0]] <= flash_dout;
	end

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	always @(posedge clk50M) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
			report_failure("timeout, the run did not finish within the cycle limit");
	end

	always @(negedge clk50M) begin
		if (dut_i.sva_i.fail_count != 0)
			report_failure("a concurrent assertion on the DUT failed");
	end

	function automatic phy_mem_pkg::half_t flash_fill(input logic [3:0] idx);
		return 16'hc3a0 ^ {4{idx}};
	endfunction

	// pairs of writes hit the same word in base and ext
	function automatic phy_mem_pkg::addr_t sram_word_addr(input int i);
		logic [5:0] idx;
		idx = 6'((i / 2) * 13 + 5);
		return {9'b0, i[0], 14'b0, idx, 2'b00};
	endfunction

	task automatic check_word(input string test, input phy_mem_pkg::word_t expected,
			input phy_mem_pkg::word_t actual);
		assert (actual === expected)
		else
			report_failure($sformatf("** Error %s expected %h actual %h",
				test, expected, actual));
	endtask

	// called 1 ns after a rising edge, returns 1 ns after the latch edge
	task automatic bus_write(input phy_mem_pkg::addr_t a, input phy_mem_pkg::word_t d);
		addr = a;
		data_in = d;
		is_write = 1'b1;
		@(posedge clk50M);
		#1;
		is_write = 1'b0;
	endtask

	task automatic bus_read(input phy_mem_pkg::addr_t a, output phy_mem_pkg::word_t d);
		addr = a;
		#1;
		d = data_out;
		@(posedge clk50M);
		#1;
	endtask

	task automatic wait_idle(output int cycles);
		cycles = 0;
		do begin
			@(posedge clk50M);
			#1;
			cycles++;
		end while (busy);
	endtask

	initial begin
		int                 cycles;
		phy_mem_pkg::word_t rd;
		phy_mem_pkg::word_t wdata;
		phy_mem_pkg::word_t wr [0:7];
		phy_mem_pkg::addr_t a;
		void'($urandom(32'hacb3_c695));
		rst = 1'b1;
		addr = '0;
		data_in = '0;
		is_write = 1'b0;
		rom_selector = 1'b0;
		com_data_in = '0;
		com_read_ready = 1'b0;
		com_write_ready = 1'b0;
		kbd_data = '0;
		for (int i = 0; i < 64; i++) begin
			base_mem[i[5:0]] = 32'hba5e_0000 | 32'(i);
			ext_mem[i[5:0]] = 32'he7e0_0000 | 32'(i);
		end
		for (int i = 0; i < 16; i++)
			flash_mem[i[3:0]] = flash_fill(i[3:0]);
		repeat (2) @(posedge clk50M);
		#1;
		rst = 1'b0;

		for (int i = 0; i < 8; i++) begin
			wr[i] = $urandom;
			bus_write(sram_word_addr(i), wr[i]);
			wait_idle(cycles);
			check_word("sram_busy", 3, cycles);
		end
		for (int i = 0; i < 8; i++) begin
			bus_read(sram_word_addr(i), rd);
			check_word("sram_read", wr[i], rd);
		end

		// flash halfword index is addr[4:1]
		for (int k = 1; k < 3; k++) begin
			wr[k] = $urandom;
			bus_write({`FLASH_PREFIX, 24'(4 * k)}, wr[k]);
			wait_idle(cycles);
			check_word("flash_busy", 7, cycles);
			bus_read({`FLASH_PREFIX, 24'(4 * k)}, rd);
			check_word("flash_read", {16'h0, wr[k][15:0]}, rd);
		end
		bus_read({`FLASH_PREFIX, 24'h14}, rd);
		check_word("flash_fill", {16'h0, flash_fill(4'd10)}, rd);

		wdata = $urandom;
		bus_write(`COM_DATA_ADDR, wdata);
		check_word("com_write_en", 1, 32'(enable_com_write));
		check_word("com_data_out", 32'(wdata[7:0]), 32'(com_data_out));
		wait_idle(cycles);
		check_word("com_write_en_end", 0, 32'(enable_com_write));
		for (int s = 0; s < 4; s++) begin
			{com_read_ready, com_write_ready} = 2'(s);
			bus_read(`COM_STAT_ADDR, rd);
			check_word("com_status", s, rd);
		end
		com_data_in = 8'($urandom);
		bus_read(`COM_DATA_ADDR, rd);
		check_word("com_read", {24'h0, com_data_in}, rd);
		check_word("com_ack", 1, 32'(int_com_ack));
		bus_read(32'h2000_0000, rd);  // unmapped
		check_word("unmapped_read", 0, rd);
		check_word("com_ack_end", 0, 32'(int_com_ack));

		wdata = $urandom;
		bus_write(`SEGDISP_ADDR, wdata);
		check_word("segdisp", wdata, segdisp);
		wait_idle(cycles);
		a = `VGA_ADDR_START + 32'h0001_2344;
		bus_write(a, wdata);
		check_word("vga_we", 1, 32'(vga_write_enable));
		check_word("vga_addr", (a - `VGA_ADDR_START) >> 2, 32'(vga_write_addr));
		check_word("vga_data", 32'(wdata[7:0]), 32'(vga_write_data));
		wait_idle(cycles);
		check_word("vga_busy", 1, cycles);
		check_word("vga_we_end", 0, 32'(vga_write_enable));

		for (int sel = 0; sel < 2; sel++) begin
			rom_selector = sel[0];
			for (int i = 0; i < `ROM_DEPTH; i++) begin
				bus_read({`ROM_BASE, 12'(4 * i)}, rd);
				check_word("rom_read", phy_mem_pkg::rom_image[sel[0]][i[3:0]], rd);
			end
		end

		kbd_data = 8'($urandom);
		bus_read(`KEYBOARD_ADDR, rd);
		check_word("kbd_read", {24'h0, kbd_data}, rd);
		check_word("kbd_ack", 1, 32'(kbd_int_ack));
		bus_read(32'h0F00_0004, rd);
		check_word("unmapped_read", 0, rd);
		check_word("kbd_ack_end", 0, 32'(kbd_int_ack));

		@(posedge clk50M);
		#1;
		if (dut_i.sva_i.fail_count != 0) begin
			report_failure("a concurrent assertion on the DUT failed");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
verilog/phy_mem_pkg.sv
verilog/phy_addr_decode.sv
verilog/phy_mem_ctrl.sv
verilog/phy_sram_port.sv
verilog/phy_flash_port.sv
verilog/phy_read_mux.sv
verilog/phy_mem_top.sv
tb/tb_clock.sv
tb/phy_mem_sva.sv
tb/phy_mem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the phy_mem testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG='*** TEST FAILED ***'

if ! verilator --binary --timing --assert --top-module phy_mem_tb \
		-f all.f -o phy_mem_sim; then
	echo "build failed"
	exit 1
fi

# error limit raised so assertion failures reach the testbench report
./obj_dir/phy_mem_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qF "$FAIL_MSG" "$LOG"; then
	echo "simulation failed, see $LOG"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
echo "simulation passed"
exit 0
